// ==== logic/udp_defines.svh ====
`ifndef UDP_DEFINES_SVH
`define UDP_DEFINES_SVH

// **************************************************
// board identity and default peer
// **************************************************
`define BOARD_MAC    48'ha0_b1_c2_d3_e1_e1  // source MAC
`define BOARD_IP     32'hc0_a8_01_0b        // 192.168.1.11
`define DEF_DES_MAC  48'h84_a9_38_bf_c9_a0  // used when descriptor MAC is zero
`define DEF_DES_IP   32'ha9_fe_33_78        // 169.254.51.120

// same port on both ends
`define UDP_PORT     16'd1234

// queue depths
`define DESC_DEPTH   4
`define DATA_DEPTH   512  // payload words

`endif

// ==== logic/eth_pkg.sv ====
package eth_pkg;

    // **************************************************
    // field types
    // **************************************************
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [7:0]  gmii_byte_t;

    // **************************************************
    // protocol constants
    // **************************************************
    localparam gmii_byte_t  ETH_PREAMBLE   = 8'h55;
    localparam gmii_byte_t  ETH_SFD        = 8'hd5;   // start of frame delimiter
    localparam logic [15:0] ETH_TYPE_IP    = 16'h0800;

    localparam logic [7:0]  IP_VER_IHL     = 8'h45;   // v4, five 32-bit words
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000; // don't fragment
    localparam logic [7:0]  IP_TTL         = 8'h40;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // 46 byte minimum minus 28 header bytes
    localparam logic [15:0] MIN_PAYLOAD    = 16'd18;
    localparam logic [15:0] IP_UDP_HDR_LEN = 16'd28;
    localparam logic [15:0] UDP_HDR_LEN    = 16'd8;

endpackage

// ==== logic/udp_tx_pkg.sv ====
package udp_tx_pkg;

    typedef logic [15:0] payload_word_t;  // high byte goes out first

    // one queued frame request, 96 bits
    typedef struct packed {
        logic [15:0]        byte_num;  // payload bytes, unpadded
        eth_pkg::mac_addr_t des_mac;   // zero selects the default
        eth_pkg::ip_addr_t  des_ip;    // zero selects the default
    } udp_desc_t;

    // **************************************************
    // sender FSM, one-hot
    // **************************************************
    typedef enum logic [6:0] {
        st_idle      = 7'b000_0001,
        st_check_sum = 7'b000_0010,
        st_preamble  = 7'b000_0100,
        st_eth_head  = 7'b000_1000,
        st_ip_head   = 7'b001_0000,
        st_tx_data   = 7'b010_0000,
        st_crc       = 7'b100_0000
    } tx_state_t;

endpackage

// ==== logic/crc_if.sv ====
`timescale 1ns/1ps

interface crc_if;

    logic                crc_en;    // one byte per cycle
    logic                crc_clr;   // back to all ones
    eth_pkg::gmii_byte_t crc_d;     // byte on the wire
    logic [31:0]         crc_data;  // current register
    eth_pkg::gmii_byte_t crc_next;  // upper byte after this update

    modport sender (
        output crc_en, crc_clr, crc_d,
        input  crc_data, crc_next
    );

    modport engine (
        input  crc_en, crc_clr, crc_d,
        output crc_data, crc_next
    );

endinterface

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr_en,
    input  item_t wr_data,
    input  logic  rd_en,
    output item_t rd_data,
    output logic  empty,
    output logic  full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    item_t          mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           do_wr;
    logic           do_rd;

    assign do_wr = wr_en && !full;   // write while full is lost
    assign do_rd = rd_en && !empty;
    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // storage and read register
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr];  // valid the cycle after rd_en
    end

    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
        else $error("sync_fifo: write while full, item dropped");
    assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty)
        else $error("sync_fifo: read while empty");

endmodule

// ==== logic/crc32_d8.sv ====
`timescale 1ns/1ps

// 802.3 CRC-32, byte per cycle, data bits taken lsb first
module crc32_d8 (
    input  logic      clk,
    input  logic      rst_n,
    crc_if.engine     crc
);

    localparam logic [31:0] poly = 32'h04c1_1db7;

    logic [31:0] crc_reg;
    logic [31:0] crc_nxt;

    // eight serial steps unrolled
    always_comb begin
        crc_nxt = crc_reg;
        for (int i = 0; i < 8; i++) begin
            if (crc_nxt[31] ^ crc.crc_d[i])
                crc_nxt = {crc_nxt[30:0], 1'b0} ^ poly;
            else
                crc_nxt = {crc_nxt[30:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            crc_reg <= '1;
        else if (crc.crc_clr)
            crc_reg <= '1;  // ready for next frame
        else if (crc.crc_en)
            crc_reg <= crc_nxt;
    end

    assign crc.crc_data = crc_reg;
    assign crc.crc_next = crc_nxt[31:24];  // lets first FCS byte go out without a bubble

    // the sender must never clear in the middle of a byte stream
    assert property (@(posedge clk) disable iff (!rst_n) crc.crc_clr |-> !crc.crc_en)
        else $error("crc32_d8: clear and enable together");

endmodule

// ==== logic/udp_frame_tx.sv ====
`timescale 1ns/1ps
`include "udp_defines.svh"

module udp_frame_tx (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic                      desc_rd,
    input  udp_tx_pkg::udp_desc_t     desc,
    input  logic                      desc_empty,
    output logic                      data_rd,
    input  udp_tx_pkg::payload_word_t data_word,
    crc_if.sender                     crc,
    output logic                      gmii_tx_en,
    output eth_pkg::gmii_byte_t       gmii_txd,
    output logic                      tx_done
);

    localparam eth_pkg::mac_addr_t board_mac   = `BOARD_MAC;
    localparam eth_pkg::ip_addr_t  board_ip    = `BOARD_IP;
    localparam eth_pkg::mac_addr_t def_des_mac = `DEF_DES_MAC;
    localparam eth_pkg::ip_addr_t  def_des_ip  = `DEF_DES_IP;

    udp_tx_pkg::tx_state_t cur_state;
    udp_tx_pkg::tx_state_t next_state;

    logic                skip_en;       // advance to next state
    logic [4:0]          cnt;
    logic [1:0]          tx_bit_sel;    // byte within a 32-bit word
    logic [15:0]         data_cnt;
    logic                rd_pend;       // descriptor on queue output
    logic [15:0]         ip_id;
    logic [15:0]         tx_data_num;
    logic [15:0]         real_num;      // padded payload length
    logic [7:0]          eth_head [14];
    logic [31:0]         ip_head [7];   // IP header then UDP header
    logic [31:0]         check_buffer;
    logic [31:0]         sum_raw;
    eth_pkg::mac_addr_t  sel_mac;
    eth_pkg::ip_addr_t   sel_ip;

    // complement and reverse one CRC byte for the wire
    function automatic eth_pkg::gmii_byte_t fcs_byte(input eth_pkg::gmii_byte_t b);
        eth_pkg::gmii_byte_t r;
        for (int i = 0; i < 8; i++)
            r[i] = ~b[7-i];
        return r;
    endfunction

    assign sel_mac  = (desc.des_mac != '0) ? desc.des_mac : def_des_mac;
    assign sel_ip   = (desc.des_ip != '0) ? desc.des_ip : def_des_ip;
    assign real_num = (tx_data_num >= eth_pkg::MIN_PAYLOAD) ? tx_data_num
                                                            : eth_pkg::MIN_PAYLOAD;
    assign crc.crc_d = gmii_txd;  // every byte sent also feeds the CRC

    // header sum over the five IP words
    always_comb begin
        sum_raw = '0;
        for (int i = 0; i < 5; i++)
            sum_raw = sum_raw + {16'h0, ip_head[i][31:16]} + {16'h0, ip_head[i][15:0]};
    end

    // **************************************************
    // state register and next state
    // **************************************************
    always_comb begin
        next_state = cur_state;
        if (skip_en) begin
            unique case (cur_state)
                udp_tx_pkg::st_idle:      next_state = udp_tx_pkg::st_check_sum;
                udp_tx_pkg::st_check_sum: next_state = udp_tx_pkg::st_preamble;
                udp_tx_pkg::st_preamble:  next_state = udp_tx_pkg::st_eth_head;
                udp_tx_pkg::st_eth_head:  next_state = udp_tx_pkg::st_ip_head;
                udp_tx_pkg::st_ip_head:   next_state = udp_tx_pkg::st_tx_data;
                udp_tx_pkg::st_tx_data:   next_state = udp_tx_pkg::st_crc;
                default:                  next_state = udp_tx_pkg::st_idle;
            endcase
        end
    end

    // **************************************************
    // control and byte output
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_state   <= udp_tx_pkg::st_idle;
            skip_en     <= 1'b0;
            cnt         <= '0;
            tx_bit_sel  <= '0;
            data_cnt    <= '0;
            rd_pend     <= 1'b0;
            ip_id       <= '0;
            desc_rd     <= 1'b0;
            data_rd     <= 1'b0;
            gmii_tx_en  <= 1'b0;
            gmii_txd    <= '0;
            crc.crc_en  <= 1'b0;
            crc.crc_clr <= 1'b0;
            tx_done     <= 1'b0;
        end else begin
            cur_state   <= next_state;
            skip_en     <= 1'b0;
            desc_rd     <= 1'b0;
            data_rd     <= 1'b0;
            gmii_tx_en  <= 1'b0;
            crc.crc_en  <= 1'b0;
            crc.crc_clr <= 1'b0;
            tx_done     <= 1'b0;
            rd_pend     <= desc_rd;
            case (next_state)
                udp_tx_pkg::st_idle: begin
                    if (cur_state == udp_tx_pkg::st_crc) begin
                        tx_done     <= 1'b1;  // cycle after the last FCS byte
                        crc.crc_clr <= 1'b1;
                    end
                    if (rd_pend) begin
                        skip_en <= 1'b1;          // headers load this edge
                        ip_id   <= ip_id + 16'd1;
                    end else if (cur_state == udp_tx_pkg::st_idle && !desc_rd && !desc_empty)
                        desc_rd <= 1'b1;
                end
                udp_tx_pkg::st_check_sum: begin
                    if (cnt == 5'd3) begin
                        skip_en <= 1'b1;
                        cnt     <= '0;
                    end else
                        cnt <= cnt + 5'd1;
                end
                udp_tx_pkg::st_preamble: begin
                    gmii_tx_en <= 1'b1;
                    gmii_txd   <= (cnt == 5'd7) ? eth_pkg::ETH_SFD : eth_pkg::ETH_PREAMBLE;
                    if (cnt == 5'd7) begin
                        skip_en <= 1'b1;
                        cnt     <= '0;
                    end else
                        cnt <= cnt + 5'd1;
                end
                udp_tx_pkg::st_eth_head: begin
                    gmii_tx_en <= 1'b1;
                    crc.crc_en <= 1'b1;
                    gmii_txd   <= eth_head[cnt[3:0]];
                    if (cnt == 5'd13) begin
                        skip_en <= 1'b1;
                        cnt     <= '0;
                    end else
                        cnt <= cnt + 5'd1;
                end
                udp_tx_pkg::st_ip_head: begin
                    gmii_tx_en <= 1'b1;
                    crc.crc_en <= 1'b1;
                    tx_bit_sel <= tx_bit_sel + 2'd1;
                    gmii_txd   <= ip_head[cnt[2:0]][8 * (3 - tx_bit_sel) +: 8];
                    if (cnt == 5'd6 && tx_bit_sel == 2'd2)
                        data_rd <= (tx_data_num != '0);  // first word, two bytes early
                    if (tx_bit_sel == 2'd3) begin
                        if (cnt == 5'd6) begin
                            skip_en <= 1'b1;
                            cnt     <= '0;
                        end else
                            cnt <= cnt + 5'd1;
                    end
                end
                udp_tx_pkg::st_tx_data: begin
                    gmii_tx_en <= 1'b1;
                    crc.crc_en <= 1'b1;
                    if (data_cnt >= tx_data_num)
                        gmii_txd <= '0;                  // zero pad
                    else if (data_cnt[0])
                        gmii_txd <= data_word[7:0];
                    else
                        gmii_txd <= data_word[15:8];
                    // next word needed two bytes from now
                    data_rd <= !data_cnt[0] && ((data_cnt + 16'd2) < tx_data_num);
                    if (data_cnt == real_num - 16'd1) begin
                        skip_en  <= 1'b1;
                        data_cnt <= '0;
                    end else
                        data_cnt <= data_cnt + 16'd1;
                end
                udp_tx_pkg::st_crc: begin
                    gmii_tx_en <= 1'b1;
                    tx_bit_sel <= tx_bit_sel + 2'd1;
                    case (tx_bit_sel)
                        2'd0:    gmii_txd <= fcs_byte(crc.crc_next);
                        2'd1:    gmii_txd <= fcs_byte(crc.crc_data[23:16]);
                        2'd2:    gmii_txd <= fcs_byte(crc.crc_data[15:8]);
                        default: gmii_txd <= fcs_byte(crc.crc_data[7:0]);
                    endcase
                    if (tx_bit_sel == 2'd3)
                        skip_en <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    // **************************************************
    // header build and checksum
    // **************************************************
    always_ff @(posedge clk) begin
        if (cur_state == udp_tx_pkg::st_idle && rd_pend) begin
            tx_data_num <= desc.byte_num;
            for (int i = 0; i < 6; i++) begin
                eth_head[i]     <= sel_mac[47 - 8*i -: 8];
                eth_head[6 + i] <= board_mac[47 - 8*i -: 8];
            end
            eth_head[12] <= eth_pkg::ETH_TYPE_IP[15:8];
            eth_head[13] <= eth_pkg::ETH_TYPE_IP[7:0];
            ip_head[0] <= {eth_pkg::IP_VER_IHL, 8'h00, desc.byte_num + eth_pkg::IP_UDP_HDR_LEN};
            ip_head[1] <= {ip_id + 16'd1, eth_pkg::IP_FLAGS_DF};  // id starts at 1
            ip_head[2] <= {eth_pkg::IP_TTL, eth_pkg::IP_PROTO_UDP, 16'h0000};
            ip_head[3] <= board_ip;
            ip_head[4] <= sel_ip;
            ip_head[5] <= {`UDP_PORT, `UDP_PORT};
            ip_head[6] <= {desc.byte_num + eth_pkg::UDP_HDR_LEN, 16'h0000};  // no UDP csum
        end
        if (next_state == udp_tx_pkg::st_check_sum) begin
            case (cnt)
                5'd0:    check_buffer <= sum_raw;
                5'd1,
                5'd2:    check_buffer <= {16'h0, check_buffer[31:16]} + {16'h0, check_buffer[15:0]};
                5'd3:    ip_head[2][15:0] <= ~check_buffer[15:0];
                default: ;
            endcase
        end
    end

    // frame leaves the wire only at its end
    assert property (@(posedge clk) disable iff (!rst_n) $fell(gmii_tx_en) |-> tx_done)
        else $error("udp_frame_tx: gmii_tx_en dropped inside a frame");

endmodule

// ==== logic/udp_tx_top.sv ====
`timescale 1ns/1ps
`include "udp_defines.svh"

module udp_tx_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      desc_wr,
    input  logic [15:0]               desc_byte_num,
    input  eth_pkg::mac_addr_t        desc_des_mac,
    input  eth_pkg::ip_addr_t         desc_des_ip,
    output logic                      desc_full,
    input  logic                      data_wr,
    input  udp_tx_pkg::payload_word_t data_word,
    output logic                      data_full,
    output logic                      gmii_tx_en,
    output eth_pkg::gmii_byte_t       gmii_txd,
    output logic                      tx_done
);

    udp_tx_pkg::udp_desc_t     desc_in;
    udp_tx_pkg::udp_desc_t     desc_out;
    logic                      desc_empty;
    logic                      desc_rd;
    logic                      data_rd;
    udp_tx_pkg::payload_word_t data_out;

    crc_if crc_bus ();

    assign desc_in = '{byte_num: desc_byte_num, des_mac: desc_des_mac, des_ip: desc_des_ip};

    // frame requests
    sync_fifo #(.item_t(udp_tx_pkg::udp_desc_t), .DEPTH(`DESC_DEPTH)) desc_q (
        .clk, .rst_n,
        .wr_en   (desc_wr),
        .wr_data (desc_in),
        .rd_en   (desc_rd),
        .rd_data (desc_out),
        .empty   (desc_empty),
        .full    (desc_full)
    );

    // payload words, emptiness left to the host
    sync_fifo #(.item_t(udp_tx_pkg::payload_word_t), .DEPTH(`DATA_DEPTH)) data_q (
        .clk, .rst_n,
        .wr_en   (data_wr),
        .wr_data (data_word),
        .rd_en   (data_rd),
        .rd_data (data_out),
        .empty   (),
        .full    (data_full)
    );

    udp_frame_tx u_sender (
        .clk, .rst_n,
        .desc_rd, .desc (desc_out), .desc_empty,
        .data_rd, .data_word (data_out),
        .crc        (crc_bus),
        .gmii_tx_en, .gmii_txd, .tx_done
    );

    crc32_d8 u_crc (.clk, .rst_n, .crc (crc_bus));

endmodule

// ==== dv/tb_udp_tx.sv ====
`timescale 1ns/1ps
`include "udp_defines.svh"

module tb_udp_tx;

    localparam int TIMEOUT_CYC = 20000;  // six tests take under 3000 cycles

    localparam eth_pkg::mac_addr_t board_mac   = `BOARD_MAC;
    localparam eth_pkg::ip_addr_t  board_ip    = `BOARD_IP;
    localparam eth_pkg::mac_addr_t def_des_mac = `DEF_DES_MAC;
    localparam eth_pkg::ip_addr_t  def_des_ip  = `DEF_DES_IP;

    logic                      clk;
    logic                      rst_n;
    logic                      desc_wr;
    logic [15:0]               desc_byte_num;
    eth_pkg::mac_addr_t        desc_des_mac;
    eth_pkg::ip_addr_t         desc_des_ip;
    logic                      desc_full;
    logic                      data_wr;
    udp_tx_pkg::payload_word_t data_word;
    logic                      data_full;
    logic                      gmii_tx_en;
    eth_pkg::gmii_byte_t       gmii_txd;
    logic                      tx_done;

    eth_pkg::gmii_byte_t       rx_bytes[$];   // everything seen on GMII
    eth_pkg::gmii_byte_t       exp_bytes[$];
    logic [15:0]               rx_lens[$];
    logic [15:0]               exp_lens[$];
    udp_tx_pkg::payload_word_t pay_words[$];  // written to DUT, not yet modeled

    int   cyc = 0;
    int   errors = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   done_cnt = 0;
    int   cur_len = 0;
    int   first_en_cyc = -1;
    int   wr_cyc = 0;
    logic prev_en = 1'b0;

    udp_tx_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= TIMEOUT_CYC) begin
            $display("timeout: run still going after %0d cycles", cyc);
            $display("TEST FAIL");
            $finish;
        end
    end

    // **************************************************
    // compare tasks
    // **************************************************
    task automatic check_byte(input int idx, input eth_pkg::gmii_byte_t got,
                              input eth_pkg::gmii_byte_t exp);
        if (got !== exp) begin
            $display("Fail gmii_txd byte %0d: got 0x%h exp 0x%h", idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h exp 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h exp 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // GMII monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (gmii_tx_en) begin
            rx_bytes.push_back(gmii_txd);
            cur_len++;
            if (first_en_cyc < 0)
                first_en_cyc = cyc;
        end else if (prev_en) begin
            rx_lens.push_back(16'(cur_len));  // frame closed
            cur_len = 0;
            check_level("tx_done", tx_done, 1'b1);  // pulse follows the last FCS byte
        end
        if (tx_done)
            done_cnt++;
        prev_en = gmii_tx_en;
    end

    // reflected 802.3 CRC, one byte
    function automatic logic [31:0] crc_step(input logic [31:0] c, input eth_pkg::gmii_byte_t b);
        logic [31:0] r;
        r = c ^ {24'h0, b};
        for (int i = 0; i < 8; i++)
            r = r[0] ? ((r >> 1) ^ 32'hedb8_8320) : (r >> 1);
        return r;
    endfunction

    // **************************************************
    // frame model
    // **************************************************
    task automatic model_frame(input logic [15:0] n, input eth_pkg::mac_addr_t mac,
                               input eth_pkg::ip_addr_t ip, input logic [15:0] id);
        eth_pkg::gmii_byte_t       body[$];
        logic [15:0]               hdr[14];  // IP then UDP header, 16-bit words
        logic [31:0]               sum;
        logic [31:0]               fcs;
        udp_tx_pkg::payload_word_t w;
        eth_pkg::mac_addr_t        dmac;
        eth_pkg::ip_addr_t         dip;
        int                        plen;
        dmac = (mac == '0) ? def_des_mac : mac;
        dip  = (ip == '0) ? def_des_ip : ip;
        for (int i = 5; i >= 0; i--)
            body.push_back(dmac[8*i +: 8]);
        for (int i = 5; i >= 0; i--)
            body.push_back(board_mac[8*i +: 8]);
        body.push_back(8'h08);
        body.push_back(8'h00);
        hdr[0]  = {eth_pkg::IP_VER_IHL, 8'h00};
        hdr[1]  = n + 16'd28;
        hdr[2]  = id;
        hdr[3]  = eth_pkg::IP_FLAGS_DF;
        hdr[4]  = {eth_pkg::IP_TTL, eth_pkg::IP_PROTO_UDP};
        hdr[5]  = 16'h0000;
        hdr[6]  = board_ip[31:16];
        hdr[7]  = board_ip[15:0];
        hdr[8]  = dip[31:16];
        hdr[9]  = dip[15:0];
        hdr[10] = `UDP_PORT;
        hdr[11] = `UDP_PORT;
        hdr[12] = n + 16'd8;
        hdr[13] = 16'h0000;  // UDP checksum unused
        sum = '0;
        for (int i = 0; i < 10; i++)
            sum = sum + {16'h0, hdr[i]};
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        hdr[5] = ~sum[15:0];
        for (int i = 0; i < 14; i++) begin
            body.push_back(hdr[i][15:8]);
            body.push_back(hdr[i][7:0]);
        end
        plen = (n < 16'd18) ? 18 : int'(n);
        for (int i = 0; i < plen; i++) begin
            if (i >= int'(n)) begin
                body.push_back(8'h00);  // zero pad
            end else begin
                if (i % 2 == 0)
                    w = pay_words.pop_front();
                body.push_back((i % 2 == 0) ? w[15:8] : w[7:0]);
            end
        end
        fcs = 32'hffff_ffff;
        foreach (body[i])
            fcs = crc_step(fcs, body[i]);
        fcs = ~fcs;
        for (int i = 0; i < 7; i++)
            exp_bytes.push_back(8'h55);
        exp_bytes.push_back(8'hd5);
        foreach (body[i])
            exp_bytes.push_back(body[i]);
        for (int k = 0; k < 4; k++)
            exp_bytes.push_back(fcs[8*k +: 8]);  // low byte first
        exp_lens.push_back(16'(body.size() + 12));
    endtask

    // **************************************************
    // stimulus
    // **************************************************
    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        rx_bytes.delete();
        exp_bytes.delete();
        rx_lens.delete();
        exp_lens.delete();
        pay_words.delete();
        done_cnt     = 0;
        cur_len      = 0;
        first_en_cyc = -1;
    endtask

    task automatic load_payload(input logic [15:0] n);
        udp_tx_pkg::payload_word_t w;
        for (int i = 0; i < (int'(n) + 1) / 2; i++) begin
            w = 16'($urandom());
            pay_words.push_back(w);
            @(posedge clk);
            #1;
            data_wr   = 1'b1;
            data_word = w;
        end
        @(posedge clk);
        #1;
        data_wr = 1'b0;
    endtask

    task automatic queue_desc(input logic [15:0] n, input eth_pkg::mac_addr_t mac,
                              input eth_pkg::ip_addr_t ip);
        @(posedge clk);
        #1;
        desc_wr       = 1'b1;
        desc_byte_num = n;
        desc_des_mac  = mac;
        desc_des_ip   = ip;
        wr_cyc        = cyc + 1;  // edge that takes the write
        @(posedge clk);
        #1;
        desc_wr = 1'b0;
    endtask

    task automatic wait_done(input int frames);
        int limit;
        int waited;
        limit  = exp_bytes.size() + 24 * frames;  // wire bytes plus start-up and gaps
        waited = 0;
        while (done_cnt < frames && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (done_cnt < frames) begin
            $display("tx_done missing: %0d of %0d frames finished in %0d cycles",
                     done_cnt, frames, limit);
            errors++;
        end
        repeat (2) @(posedge clk);  // monitor closes the last frame
    endtask

    task automatic compare_frames();
        int nb;
        if (rx_lens.size() != exp_lens.size()) begin
            $display("frame count wrong: saw %0d frames, expected %0d",
                     rx_lens.size(), exp_lens.size());
            errors++;
        end
        for (int i = 0; i < rx_lens.size() && i < exp_lens.size(); i++)
            check_len("frame length", rx_lens[i], exp_lens[i]);
        nb = (rx_bytes.size() < exp_bytes.size()) ? rx_bytes.size() : exp_bytes.size();
        for (int i = 0; i < nb; i++)
            check_byte(i, rx_bytes[i], exp_bytes[i]);
        check_len("tx_done cycles", 16'(done_cnt), 16'(exp_lens.size()));
    endtask

    task automatic end_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - start_errors);
        end
    endtask

    // **************************************************
    // directed tests
    // **************************************************
    task automatic send_long_frame();
        int e0;
        e0 = errors;
        apply_reset();
        load_payload(16'd64);
        queue_desc(16'd64, 48'h02_1a_2b_3c_4d_5e, 32'h0a_00_00_05);
        model_frame(16'd64, 48'h02_1a_2b_3c_4d_5e, 32'h0a_00_00_05, 16'd1);
        wait_done(1);
        compare_frames();
        end_test("long frame, 64 bytes", e0);
    endtask

    task automatic pad_short_odd();
        int e0;
        e0 = errors;
        apply_reset();
        load_payload(16'd5);
        queue_desc(16'd5, 48'h02_00_00_00_00_07, 32'h0a_00_00_07);
        model_frame(16'd5, 48'h02_00_00_00_00_07, 32'h0a_00_00_07, 16'd1);
        wait_done(1);
        compare_frames();
        if (rx_lens.size() > 0)
            check_len("frame length", rx_lens[0], 16'd72);
        end_test("short odd frame, 5 bytes", e0);
    endtask

    task automatic default_addresses();
        int e0;
        e0 = errors;
        apply_reset();
        load_payload(16'd20);
        queue_desc(16'd20, '0, '0);
        model_frame(16'd20, '0, '0, 16'd1);
        wait_done(1);
        compare_frames();
        if (rx_bytes.size() >= 42) begin
            for (int k = 0; k < 6; k++)
                check_byte(8 + k, rx_bytes[8 + k], def_des_mac[47 - 8*k -: 8]);
            for (int k = 0; k < 4; k++)
                check_byte(38 + k, rx_bytes[38 + k], def_des_ip[31 - 8*k -: 8]);
        end else begin
            $display("default address frame too short: %0d bytes", rx_bytes.size());
            errors++;
        end
        end_test("default addresses", e0);
    endtask

    task automatic queue_back_to_back();
        int e0;
        e0 = errors;
        apply_reset();
        load_payload(16'd40);
        load_payload(16'd17);
        load_payload(16'd100);
        queue_desc(16'd40, 48'h02_00_00_00_00_01, 32'h0a_00_00_01);
        queue_desc(16'd17, 48'h02_00_00_00_00_02, 32'h0a_00_00_02);
        queue_desc(16'd100, 48'h02_00_00_00_00_03, 32'h0a_00_00_03);
        model_frame(16'd40, 48'h02_00_00_00_00_01, 32'h0a_00_00_01, 16'd1);
        model_frame(16'd17, 48'h02_00_00_00_00_02, 32'h0a_00_00_02, 16'd2);
        model_frame(16'd100, 48'h02_00_00_00_00_03, 32'h0a_00_00_03, 16'd3);
        wait_done(3);
        compare_frames();  // three lengths means gmii_tx_en dropped between frames
        end_test("three frames back to back", e0);
    endtask

    task automatic start_timing();
        int e0;
        e0 = errors;
        apply_reset();
        check_level("gmii_tx_en", gmii_tx_en, 1'b0);
        check_level("tx_done", tx_done, 1'b0);
        load_payload(16'd30);
        queue_desc(16'd30, 48'h02_00_00_00_00_30, 32'h0a_00_00_30);
        model_frame(16'd30, 48'h02_00_00_00_00_30, 32'h0a_00_00_30, 16'd1);
        wait_done(1);
        compare_frames();
        // one cycle to pop, seven more to the first byte
        check_len("gmii_tx_en delay", 16'(first_en_cyc - wr_cyc), 16'd8);
        if (rx_bytes.size() < 8) begin
            $display("preamble missing: only %0d bytes seen", rx_bytes.size());
            errors++;
        end else begin
            for (int k = 0; k < 7; k++)
                check_byte(k, rx_bytes[k], 8'h55);
            check_byte(7, rx_bytes[7], 8'hd5);
        end
        end_test("reset state and start timing", e0);
    endtask

    task automatic fill_queues();
        int                 e0;
        eth_pkg::mac_addr_t mac;
        eth_pkg::ip_addr_t  ip;
        e0 = errors;
        apply_reset();
        check_level("desc_full", desc_full, 1'b0);
        check_level("data_full", data_full, 1'b0);
        load_payload(16'(2 * `DATA_DEPTH));  // one word per queue entry
        check_level("data_full", data_full, 1'b1);
        // empty payloads, so the full payload queue is never read
        for (int k = 0; k < 5; k++) begin
            mac = 48'h02_00_00_00_00_40 + 48'(k);
            ip  = 32'h0a_00_00_40 + 32'(k);
            queue_desc(16'd0, mac, ip);
            model_frame(16'd0, mac, ip, 16'(k + 1));
        end
        // one taken by the sender, four waiting
        check_level("desc_full", desc_full, 1'b1);
        wait_done(5);
        compare_frames();
        end_test("queue full flags", e0);
    endtask

    initial begin
        rst_n         = 1'b0;
        desc_wr       = 1'b0;
        desc_byte_num = '0;
        desc_des_mac  = '0;
        desc_des_ip   = '0;
        data_wr       = 1'b0;
        data_word     = '0;
        void'($urandom(32'h131b_17be));
        send_long_frame();
        pad_short_odd();
        default_addresses();
        queue_back_to_back();
        start_timing();
        fill_queues();
        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/eth_pkg.sv
logic/udp_tx_pkg.sv
logic/crc_if.sv
logic/sync_fifo.sv
logic/crc32_d8.sv
logic/udp_frame_tx.sv
logic/udp_tx_top.sv
dv/tb_udp_tx.sv

// ==== run.sh ====
#!/bin/sh
# build the UDP transmitter testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module tb_udp_tx -o sim_udp_tx \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_udp_tx)
echo "$out"
echo "$out" | grep -q "TEST PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
